// File: bench/blocking_cache_tests.txt
# op(R/W) nsbit addr(hex) wdata(hex) exp_data(hex) exp_denied exp_hit
# exp_hit 1 means the response must come 3 edges after acceptance
R 0 00000104 00000000 5A5A5B5E 0 0
R 0 00000104 00000000 5A5A5B5E 0 1
W 0 00000224 DEADBEEF 00000000 0 0
R 0 00000224 00000000 DEADBEEF 0 1
R 0 00000228 00000000 5A5A5872 0 1
W 0 00000220 12345678 00000000 0 1
R 0 00000220 00000000 12345678 0 1
W 0 00000034 CAFEF00D 00000000 0 0
R 0 000000B0 00000000 5A5A5AEA 0 0
R 0 00000130 00000000 5A5A5B6A 0 0
R 0 00000034 00000000 CAFEF00D 0 0
R 0 00000038 00000000 5A5A5A62 0 1
R 0 000000B4 00000000 5A5A5AEE 0 0
R 1 00000104 00000000 00000000 1 1
R 0 00000104 00000000 5A5A5B5E 0 1
W 1 00000224 FFFFFFFF 00000000 1 1
R 0 00000224 00000000 DEADBEEF 0 1
R 1 00000350 00000000 5A5A590A 0 0
R 0 00000354 00000000 00000000 1 1
R 1 00000354 00000000 5A5A590E 0 1

// File: blocking_cache.f
source/cache_pkg.sv
source/cache_way.sv
source/way_select.sv
source/cache_ctrl.sv
source/blocking_cache.sv
bench/blocking_cache_props.sv
bench/blocking_cache_tb.sv

// File: Bender.yml
package:
  name: blocking_cache

sources:
  # RTL, package first
  - files:
      - source/cache_pkg.sv
      - source/cache_way.sv
      - source/way_select.sv
      - source/cache_ctrl.sv
      - source/blocking_cache.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/blocking_cache_props.sv
      - bench/blocking_cache_tb.sv

// File: bench/blocking_cache_tb.sv
// ------------------------------
// Testbench for the blocking cache: runs the requests in the tests file
// against a line memory model with random latency and back-pressure.
// ------------------------------

`timescale 1ns/1ns

module blocking_cache_tb import cache_pkg::*; ();

  localparam int MEM_WORDS      = 1024;
  localparam int ACCEPT_TIMEOUT = 50;
  localparam int RESP_TIMEOUT   = 500;
  localparam int HIT_LATENCY    = 3;

  logic        clk          = 1'b0;
  logic        reset        = 1'b1;
  logic        req_val      = 1'b0;
  logic        req_rdy;
  cache_addr_u req_addr     = '0;
  logic        req_write    = 1'b0;
  word_t       req_wdata    = '0;
  logic        req_nsbit    = 1'b0;
  logic        resp_val;
  logic        resp_rdy     = 1'b0;
  word_t       resp_data;
  logic        resp_write;
  logic        resp_denied;
  logic        memreq_val;
  logic        memreq_rdy   = 1'b0;
  logic        memreq_write;
  cache_addr_u memreq_addr;
  line_t       memreq_data;
  logic        memresp_val  = 1'b0;
  logic        memresp_rdy;
  line_t       memresp_data = '0;

  // Memory model state
  word_t       mem [MEM_WORDS];
  integer      seed      = 64;
  logic        mem_busy  = 1'b0;
  logic [1:0]  mem_delay = '0;

  int          errors    = 0;
  int          checks    = 0;
  int          requests  = 0;
  logic        timed_out = 1'b0;

  blocking_cache dut (.*);

  bind blocking_cache blocking_cache_props props (.*);

  always #10 clk = ~clk;

  // ------------------------------
  // Line memory, one request at a time
  // ------------------------------

  always @(posedge clk) begin : mem_model
    int    base;
    word_t rnd;
    if (reset) begin
      memreq_rdy  <= 1'b0;
      memresp_val <= 1'b0;
      mem_busy    <= 1'b0;
    end else if (memresp_val) begin
      if (memresp_rdy)
        memresp_val <= 1'b0;
    end else if (mem_busy) begin
      if (mem_delay == 2'd0) begin
        memresp_val <= 1'b1;
        mem_busy    <= 1'b0;
      end else begin
        mem_delay <= mem_delay - 2'd1;
      end
    end else if (memreq_val && memreq_rdy) begin
      base = (memreq_addr.raw >> 2) % MEM_WORDS;
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
        if (memreq_write)
          mem[base + k] = memreq_data[k*WORD_W +: WORD_W];
        memresp_data[k*WORD_W +: WORD_W] <= mem[base + k];
      end
      rnd = $random(seed);
      mem_delay  <= rnd[1:0];
      memreq_rdy <= 1'b0;
      mem_busy   <= 1'b1;
    end else begin
      rnd = $random(seed);
      memreq_rdy <= rnd[0];
    end
  end

  // CPU takes responses about three cycles in four
  always @(posedge clk) begin : backpressure
    word_t rnd;
    if (reset) begin
      resp_rdy <= 1'b0;
    end else begin
      rnd = $random(seed);
      resp_rdy <= (rnd[1:0] != 2'b00);
    end
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED %0t ns: %s is %0d edges, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout: %s did not arrive within its limit at %0t ns", what, $time);
  endtask

  // Response payload, and no new request while it is pending
  task automatic inspect_response(input word_t exp_data, input logic exp_denied,
                                  input logic exp_write);
    check_flag(resp_val, 1'b1, "resp_val");
    check_word(resp_data, exp_data, "resp_data");
    check_flag(resp_denied, exp_denied, "resp_denied");
    check_flag(resp_write, exp_write, "resp_write");
    check_flag(req_rdy, 1'b0, "req_rdy while a response is pending");
  endtask

  // ------------------------------
  // One request from start to response transfer
  // ------------------------------

  task automatic run_request(input logic [7:0] op, input logic ns, input word_t addr,
                             input word_t wdata, input word_t exp_data,
                             input logic exp_denied, input logic exp_hit);
    int   waited;
    logic is_write;
    is_write = (op == "W");
    requests++;
    @(posedge clk);
    req_val      <= 1'b1;
    req_addr.raw <= addr;
    req_write    <= is_write;
    req_wdata    <= wdata;
    req_nsbit    <= ns;
    waited = 0;
    @(negedge clk);
    while (!req_rdy && waited < ACCEPT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      report_timeout("req_rdy for a new request");
      return;
    end
    // Acceptance edge
    @(posedge clk);
    req_val <= 1'b0;
    waited = 1;
    @(negedge clk);
    while (!resp_val && waited < RESP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_val) begin
      report_timeout("resp_val");
      return;
    end
    if (exp_hit)
      check_latency(waited, HIT_LATENCY, "hit response latency");
    inspect_response(exp_data, exp_denied, is_write);
    waited = 0;
    while (!resp_rdy && waited < RESP_TIMEOUT) begin
      @(negedge clk);
      waited++;
      inspect_response(exp_data, exp_denied, is_write);
    end
    if (!resp_rdy) begin
      report_timeout("resp_rdy from the back-pressure driver");
      return;
    end
    // Response transfers here
    @(posedge clk);
  endtask

  initial begin : main
    int         fd;
    int         n;
    int         ns;
    int         den;
    int         hit;
    string      line;
    logic [7:0] op;
    word_t      addr;
    word_t      wdata;
    word_t      exp_data;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = word_t'(i * 4) ^ 32'h5A5A5A5A;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("bench/blocking_cache_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open bench/blocking_cache_tests.txt");
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %d %h %h %h %d %d", op, ns, addr, wdata, exp_data, den, hit);
          if (n == 7) begin
            run_request(op, ns[0], addr, wdata, exp_data, den[0], hit[0]);
          end else begin
            errors++;
            $display("Tests file line could not be read: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (requests == 0) begin
      errors++;
      $display("No requests were run");
    end
    $display("Requests %0d, checks %0d, errors %0d", requests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: bench/blocking_cache_props.sv
// ------------------------------
// Handshake assertions for the blocking cache.
// Bound to the top level from the testbench.
// ------------------------------

`timescale 1ns/1ns

module blocking_cache_props import cache_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        req_rdy,
  input logic        resp_val,
  input logic        resp_rdy,
  input word_t       resp_data,
  input logic        resp_write,
  input logic        resp_denied,
  input logic        memreq_val,
  input logic        memreq_rdy,
  input logic        memreq_write,
  input cache_addr_u memreq_addr,
  input line_t       memreq_data
);

  // Response stays put until the CPU takes it
  resp_held: assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_data)
                              && $stable(resp_write) && $stable(resp_denied)
  ) else $error("resp_val or its payload changed before resp_rdy");

  // Refill requests carry no meaningful data, so data only matters on write-back
  memreq_held: assert property (
    @(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_addr)
                                  && $stable(memreq_write)
                                  && (!memreq_write || $stable(memreq_data))
  ) else $error("memreq_val or its payload changed before memreq_rdy");

  // One item in flight
  one_in_flight: assert property (
    @(posedge clk) disable iff (reset)
    !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

endmodule

// File: source/blocking_cache.sv
// ----------------------------
// Top of the blocking cache: controller, two ways and way select.
// CPU side takes word requests, memory side moves whole lines.
// ----------------------------

`timescale 1ns/1ns

module blocking_cache import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // CPU request and response
  input  logic        req_val,
  output logic        req_rdy,
  input  cache_addr_u req_addr,
  input  logic        req_write,
  input  word_t       req_wdata,
  input  logic        req_nsbit,
  output logic        resp_val,
  input  logic        resp_rdy,
  output word_t       resp_data,
  output logic        resp_write,
  output logic        resp_denied,

  // Memory request and response
  output logic        memreq_val,
  input  logic        memreq_rdy,
  output logic        memreq_write,
  output cache_addr_u memreq_addr,
  output line_t       memreq_data,
  input  logic        memresp_val,
  output logic        memresp_rdy,
  input  line_t       memresp_data
);

  cache_addr_u addr;
  logic        lat_nsbit;
  word_t       lat_wdata;
  line_t       fill_line;
  logic        line_wen;
  logic        word_wen;
  logic        set_dirty;
  logic        lru_en;
  logic        record_en;

  logic        hit_0, hit_1;
  logic        secure_ok_0, secure_ok_1;
  logic        dirty_0, dirty_1;
  line_t       line_0, line_1;
  tag_t        tag_0, tag_1;
  logic        line_wen_0, line_wen_1;
  logic        word_wen_0, word_wen_1;

  logic        any_hit;
  logic        denied;
  logic        victim_dirty;
  tag_t        victim_tag;
  line_t       sel_line;

  cache_ctrl ctrl (.*);

  cache_way way0 (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .req_nsbit (lat_nsbit),
    .line_wen  (line_wen_0),
    .word_wen  (word_wen_0),
    .set_dirty (set_dirty),
    .fill_line (fill_line),
    .wdata     (lat_wdata),
    .hit       (hit_0),
    .secure_ok (secure_ok_0),
    .dirty     (dirty_0),
    .line_out  (line_0),
    .tag_out   (tag_0)
  );

  cache_way way1 (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .req_nsbit (lat_nsbit),
    .line_wen  (line_wen_1),
    .word_wen  (word_wen_1),
    .set_dirty (set_dirty),
    .fill_line (fill_line),
    .wdata     (lat_wdata),
    .hit       (hit_1),
    .secure_ok (secure_ok_1),
    .dirty     (dirty_1),
    .line_out  (line_1),
    .tag_out   (tag_1)
  );

  way_select sel (.*);

endmodule

// File: source/cache_ctrl.sv
// ----------------------------
// Cache controller: latches one request, walks the FSM through lookup,
// eviction and refill, and holds the response until it is taken.
// ----------------------------

`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  input  cache_addr_u req_addr,
  input  logic        req_write,
  input  word_t       req_wdata,
  input  logic        req_nsbit,
  input  logic        resp_rdy,
  input  logic        memreq_rdy,
  input  logic        memresp_val,
  input  line_t       memresp_data,
  input  logic        any_hit,
  input  logic        denied,
  input  logic        victim_dirty,
  input  tag_t        victim_tag,
  input  line_t       sel_line,
  output logic        req_rdy,
  output logic        resp_val,
  output word_t       resp_data,
  output logic        resp_write,
  output logic        resp_denied,
  output logic        memreq_val,
  output logic        memreq_write,
  output cache_addr_u memreq_addr,
  output line_t       memreq_data,
  output logic        memresp_rdy,
  output cache_addr_u addr,
  output logic        lat_nsbit,
  output word_t       lat_wdata,
  output line_t       fill_line,
  output logic        line_wen,
  output logic        word_wen,
  output logic        set_dirty,
  output logic        lru_en,
  output logic        record_en
);

  localparam logic [3:0] S_IDLE          = 4'd0;
  localparam logic [3:0] S_TAG_CHECK     = 4'd1;
  localparam logic [3:0] S_READ_ACCESS   = 4'd2;
  localparam logic [3:0] S_WRITE_ACCESS  = 4'd3;
  localparam logic [3:0] S_EMPTY_RESP    = 4'd4;
  localparam logic [3:0] S_REFILL_REQ    = 4'd5;
  localparam logic [3:0] S_REFILL_WAIT   = 4'd6;
  localparam logic [3:0] S_REFILL_UPDATE = 4'd7;
  localparam logic [3:0] S_EVICT_REQ     = 4'd8;
  localparam logic [3:0] S_EVICT_WAIT    = 4'd9;
  localparam logic [3:0] S_WAIT          = 4'd10;

  logic [3:0] state;
  logic [3:0] state_next;
  logic       lat_write;
  tag_t       mem_tag;

  // ----------------------------
  // FSM
  // ----------------------------

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:
        if (req_val && req_rdy) state_next = S_TAG_CHECK;
      S_TAG_CHECK:
        if (denied)            state_next = S_EMPTY_RESP;
        else if (any_hit)      state_next = lat_write ? S_WRITE_ACCESS : S_READ_ACCESS;
        else if (victim_dirty) state_next = S_EVICT_REQ;
        else                   state_next = S_REFILL_REQ;
      S_READ_ACCESS, S_WRITE_ACCESS, S_EMPTY_RESP:
        state_next = S_WAIT;
      S_REFILL_REQ:
        if (memreq_rdy) state_next = S_REFILL_WAIT;
      S_REFILL_WAIT:
        if (memresp_val) state_next = S_REFILL_UPDATE;
      // Line is now resident, so retry as a hit
      S_REFILL_UPDATE:
        state_next = lat_write ? S_WRITE_ACCESS : S_READ_ACCESS;
      S_EVICT_REQ:
        if (memreq_rdy) state_next = S_EVICT_WAIT;
      S_EVICT_WAIT:
        if (memresp_val) state_next = S_REFILL_REQ;
      S_WAIT:
        if (resp_rdy) state_next = S_IDLE;
      default:
        state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      req_rdy <= 1'b0;
    end else begin
      state   <= state_next;
      req_rdy <= (state_next == S_IDLE);
    end
  end

  // Control outputs per state
  always_comb begin
    resp_val     = (state == S_WAIT);
    memreq_val   = (state == S_REFILL_REQ) || (state == S_EVICT_REQ);
    memreq_write = (state == S_EVICT_REQ);
    memresp_rdy  = (state == S_REFILL_WAIT) || (state == S_EVICT_WAIT);
    record_en    = (state == S_TAG_CHECK);
    line_wen     = (state == S_REFILL_UPDATE);
    word_wen     = (state == S_WRITE_ACCESS);
    lru_en       = (state == S_READ_ACCESS) || (state == S_WRITE_ACCESS);
    // A write miss allocates the line already dirty
    set_dirty    = line_wen && lat_write;
  end

  // ----------------------------
  // Request latch and refill data
  // ----------------------------

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      addr      <= req_addr;
      lat_write <= req_write;
      lat_wdata <= req_wdata;
      lat_nsbit <= req_nsbit;
    end
    if (state == S_REFILL_WAIT && memresp_val)
      fill_line <= memresp_data;
  end

  // Victim address on evict, own address on refill, always line aligned
  assign mem_tag         = (state == S_EVICT_REQ) ? victim_tag : addr.f.tag;
  assign memreq_addr.raw = {mem_tag, addr.f.idx, {(ADDR_W - TAG_W - IDX_W){1'b0}}};
  assign memreq_data     = sel_line;

  // ----------------------------
  // Response register
  // ----------------------------

  always_ff @(posedge clk) begin
    case (state)
      S_READ_ACCESS: begin
        resp_data   <= sel_line[addr.f.woff*WORD_W +: WORD_W];
        resp_write  <= 1'b0;
        resp_denied <= 1'b0;
      end
      S_WRITE_ACCESS: begin
        resp_data   <= '0;
        resp_write  <= 1'b1;
        resp_denied <= 1'b0;
      end
      S_EMPTY_RESP: begin
        resp_data   <= '0;
        resp_write  <= lat_write;
        resp_denied <= 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: source/way_select.sv
// ----------------------------
// Combines both ways' lookups, keeps LRU per set and the chosen way,
// and steers write enables to that way only.
// ----------------------------

`timescale 1ns/1ns

module way_select import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  cache_addr_u addr,
  input  logic        record_en,
  input  logic        lru_en,
  input  logic        line_wen,
  input  logic        word_wen,
  input  logic        hit_0,
  input  logic        hit_1,
  input  logic        secure_ok_0,
  input  logic        secure_ok_1,
  input  logic        dirty_0,
  input  logic        dirty_1,
  input  line_t       line_0,
  input  line_t       line_1,
  input  tag_t        tag_0,
  input  tag_t        tag_1,
  output logic        any_hit,
  output logic        denied,
  output logic        victim_dirty,
  output tag_t        victim_tag,
  output line_t       sel_line,
  output logic        line_wen_0,
  output logic        line_wen_1,
  output logic        word_wen_0,
  output logic        word_wen_1
);

  logic                good_0;
  logic                good_1;
  logic                way_in;
  logic                way_q;
  logic                sel_way;
  logic [NUM_SETS-1:0] lru_q;

  assign good_0  = hit_0 && secure_ok_0;
  assign good_1  = hit_1 && secure_ok_1;
  assign any_hit = good_0 || good_1;
  // Tag present but owned by the other security domain
  assign denied  = (hit_0 || hit_1) && !any_hit;

  // Hit way, or the LRU way of the set on a miss
  assign way_in = good_0 ? 1'b0 : (good_1 ? 1'b1 : lru_q[addr.f.idx]);

  // During tag check the way is not recorded yet, so look through
  assign sel_way = record_en ? way_in : way_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      way_q <= 1'b0;
      lru_q <= '0;
    end else begin
      if (record_en)
        way_q <= way_in;
      if (lru_en)
        lru_q[addr.f.idx] <= ~way_q;
    end
  end

  assign sel_line     = sel_way ? line_1  : line_0;
  assign victim_tag   = sel_way ? tag_1   : tag_0;
  assign victim_dirty = sel_way ? dirty_1 : dirty_0;

  assign line_wen_0 = line_wen && !sel_way;
  assign line_wen_1 = line_wen &&  sel_way;
  assign word_wen_0 = word_wen && !sel_way;
  assign word_wen_1 = word_wen &&  sel_way;

endmodule

// File: source/cache_way.sv
// ----------------------------
// One way of the cache: valid, dirty, nsbit, tag and data per set.
// Read side is combinational from the latched index, writes on the edge.
// ----------------------------

`timescale 1ns/1ns

module cache_way import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // Latched request
  input  cache_addr_u addr,
  input  logic        req_nsbit,

  // Write controls, already steered to this way
  input  logic        line_wen,
  input  logic        word_wen,
  input  logic        set_dirty,
  input  line_t       fill_line,
  input  word_t       wdata,

  // Lookup results
  output logic        hit,
  output logic        secure_ok,
  output logic        dirty,
  output line_t       line_out,
  output tag_t        tag_out
);

  idx_t idx;

  // Status bits clear on reset
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  // Storage arrays
  logic                nsb_q  [NUM_SETS];
  tag_t                tag_q  [NUM_SETS];
  line_t               data_q [NUM_SETS];

  assign idx = addr.f.idx;

  // ----------------------------
  // Lookup
  // ----------------------------

  assign hit       = valid_q[idx] && (tag_q[idx] == addr.f.tag);
  assign secure_ok = (nsb_q[idx] == req_nsbit);
  assign dirty     = dirty_q[idx];
  assign line_out  = data_q[idx];
  assign tag_out   = tag_q[idx];

  // ----------------------------
  // Update
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (line_wen) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= set_dirty;
    end else if (word_wen) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_wen) begin
      // Fill records the owner's security bit along with the tag
      data_q[idx] <= fill_line;
      tag_q[idx]  <= addr.f.tag;
      nsb_q[idx]  <= req_nsbit;
    end else if (word_wen) begin
      data_q[idx][addr.f.woff*WORD_W +: WORD_W] <= wdata;
    end
  end

endmodule

// File: source/cache_pkg.sv
// ----------------------------
// Shared sizes and types for the two-way blocking L1 data cache.
// Import with cache_pkg::* in any module that uses them.
// ----------------------------

package cache_pkg;

  // ----------------------------
  // Geometry
  // ----------------------------

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
  localparam int NUM_SETS       = 8;

  // Address split, from the bottom up
  localparam int BOFF_W = 2;
  localparam int WOFF_W = $clog2(WORDS_PER_LINE);
  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int TAG_W  = ADDR_W - IDX_W - WOFF_W - BOFF_W;

  // ----------------------------
  // Types
  // ----------------------------

  typedef logic [WORD_W-1:0] word_t;

  // Word k of a line sits at bits 32k and up
  typedef logic [LINE_W-1:0] line_t;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  // Request address, either as a plain word for the memory side
  // or split into fields for the arrays
  typedef union packed {
    word_t raw;
    struct packed {
      tag_t              tag;
      idx_t              idx;
      logic [WOFF_W-1:0] woff;
      logic [BOFF_W-1:0] boff;
    } f;
  } cache_addr_u;

endpackage
